// File: files.f
+incdir+source
source/soc_pkg.sv
source/ahb_decoder.sv
source/ahb_sram.sv
source/ahb_apb_bridge.sv
source/apb_gpio.sv
source/apb_read_mux.sv
source/riscv_soc.sv
test/soc_properties.sv
test/tb_riscv_soc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_riscv_soc
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(wildcard source/*.sv source/*.svh test/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): files.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f files.f

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/tb_riscv_soc.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module tb_riscv_soc;

  localparam int READY_TIMEOUT = 50;

  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        chk_data;
    logic [31:0] exp_data;
    logic        exp_err;
  } op_t;

  logic               clk;
  logic               reset_n;
  soc_pkg::ahb_req_t  ahb_req;
  soc_pkg::ahb_rsp_t  ahb_rsp;
  soc_pkg::gpio_bus_t gpio_in;
  soc_pkg::gpio_bus_t gpio_out;
  soc_pkg::gpio_bus_t gpio_dir;

  // reference state built from the memory map
  logic [31:0]        mem_model [logic [31:0]];
  soc_pkg::gpio_bus_t exp_out;
  soc_pkg::gpio_bus_t exp_dir;
  op_t                ops [$];
  logic [31:0]        lcg_state;
  logic [31:0]        rnd;
  int                 data_errs;
  int                 resp_errs;
  int                 pin_errs;
  bit                 timed_out;

  riscv_soc DUT (
    .clk        (clk),
    .reset_n    (reset_n),
    .ahb_req_i  (ahb_req),
    .ahb_rsp_o  (ahb_rsp),
    .gpio_in_i  (gpio_in),
    .gpio_out_o (gpio_out),
    .gpio_dir_o (gpio_dir)
  );

  bind riscv_soc soc_properties props (
    .clk       (clk),
    .reset_n   (reset_n),
    .psel_i    (psel),
    .apb_req_i (apb_req),
    .ahb_rsp_i (ahb_rsp_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] gpio_addr(input int blk, input int off);
    return `GPIO_BASE + blk * `GPIO_STRIDE + off * 4;
  endfunction

  // queue one transfer and work out its expected response
  function automatic void add_op(input logic wr, input logic [31:0] addr,
                                 input logic [31:0] wdata);
    op_t op;
    int  blk;
    int  off;
    op.wr = wr;
    op.addr = addr;
    op.wdata = wdata;
    op.exp_data = '0;
    op.exp_err = 1'b1;
    blk = -1;
    off = int'(addr[11:2]);
    for (int b = 0; b < `APB_SLAVES_NUM; b++)
    begin
      if ((addr & `GPIO_MASK) == gpio_addr(b, 0))
        blk = b;
    end
    if ((addr & `IRAM_MASK) == `IRAM_BASE || (addr & `DRAM_MASK) == `DRAM_BASE)
    begin
      op.exp_err = 1'b0;
      if (wr)
        mem_model[addr] = wdata;
      else
        op.exp_data = mem_model[addr];
    end
    else if (blk >= 0 && (off == `GPIO_REG_OUT || off == `GPIO_REG_DIR ||
                          (off == `GPIO_REG_IN && !wr)))
    begin
      op.exp_err = 1'b0;
      case (off)
        `GPIO_REG_OUT:
        begin
          if (wr)
            exp_out[blk] = wdata[`GPIO_W-1:0];
          op.exp_data = 32'(exp_out[blk]);
        end
        `GPIO_REG_DIR:
        begin
          if (wr)
            exp_dir[blk] = wdata[`GPIO_W-1:0];
          op.exp_data = 32'(exp_dir[blk]);
        end
        default: op.exp_data = 32'(gpio_in[blk]);
      endcase
    end
    op.chk_data = !wr && !op.exp_err;
    ops.push_back(op);
  endfunction

  // every known memory word and gpio register
  function automatic void add_readback();
    foreach (mem_model[a])
      add_op(1'b0, a, 32'h0);
    for (int b = 0; b < `APB_SLAVES_NUM; b++)
    begin
      for (int r = 0; r <= `GPIO_REG_IN; r++)
        add_op(1'b0, gpio_addr(b, r), 32'h0);
    end
  endfunction

  task automatic check_rsp(input op_t op);
    assert (ahb_rsp.resp === op.exp_err)
    else
    begin
      resp_errs++;
      $display("Fail at %0t: ahb_rsp_o.resp for addr %h expected %b got %b",
               $time, op.addr, op.exp_err, ahb_rsp.resp);
    end
    if (op.chk_data)
    begin
      assert (ahb_rsp.rdata === op.exp_data)
      else
      begin
        data_errs++;
        $display("Fail at %0t: ahb_rsp_o.rdata for addr %h expected %h got %h",
                 $time, op.addr, op.exp_data, ahb_rsp.rdata);
      end
    end
  endtask

  // pipelined master, next address phase overlaps the current data phase
  task automatic run_ops();
    op_t dp;
    bit  dp_valid;
    int  idx;
    int  wait_cnt;
    dp_valid = 1'b0;
    idx = 0;
    wait_cnt = 0;
    while (!timed_out && (idx < ops.size() || dp_valid))
    begin
      @(negedge clk);
      if (dp_valid)
        ahb_req.wdata = dp.wdata;
      if (ahb_rsp.ready)
      begin
        wait_cnt = 0;
        if (dp_valid)
          check_rsp(dp);
        dp_valid = (idx < ops.size());
        ahb_req.trans = dp_valid;
        if (dp_valid)
        begin
          dp = ops[idx];
          idx++;
          ahb_req.write = dp.wr;
          ahb_req.addr = dp.addr;
        end
      end
      else
      begin
        wait_cnt++;
        if (wait_cnt > READY_TIMEOUT)
        begin
          $display("Timeout: ready stayed low for %0d cycles at %0t", wait_cnt, $time);
          timed_out = 1'b1;
        end
      end
    end
    ops.delete();
  endtask

  task automatic check_pins();
    @(negedge clk);
    assert (gpio_out === exp_out)
    else
    begin
      pin_errs++;
      $display("Fail at %0t: gpio_out_o expected %h got %h", $time, exp_out, gpio_out);
    end
    assert (gpio_dir === exp_dir)
    else
    begin
      pin_errs++;
      $display("Fail at %0t: gpio_dir_o expected %h got %h", $time, exp_dir, gpio_dir);
    end
  endtask

  initial
  begin
    reset_n = 1'b0;
    ahb_req = '0;
    gpio_in = '0;
    exp_out = '0;
    exp_dir = '0;
    lcg_state = 32'h5308;
    data_errs = 0;
    resp_errs = 0;
    pin_errs = 0;
    timed_out = 1'b0;
    repeat (16) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    assert ({ahb_rsp.ready, ahb_rsp.resp} === 2'b10)
    else
    begin
      resp_errs++;
      $display("Fail at %0t: ahb_rsp_o ready/resp expected 10 got %b%b",
               $time, ahb_rsp.ready, ahb_rsp.resp);
    end
    check_pins();

    // same offsets in both srams, then an overwrite read straight back
    for (int i = 0; i < 4; i++)
    begin
      add_op(1'b1, `IRAM_BASE + i * 32'h84, lcg_next());
      add_op(1'b1, `DRAM_BASE + i * 32'h84, lcg_next());
    end
    add_op(1'b1, `IRAM_BASE + 32'h3FC, lcg_next());
    add_op(1'b1, `DRAM_BASE + 32'h84, lcg_next());
    add_op(1'b0, `DRAM_BASE + 32'h84, 32'h0);
    add_readback();
    run_ops();

    for (int b = 0; b < `APB_SLAVES_NUM; b++)
    begin
      add_op(1'b1, gpio_addr(b, `GPIO_REG_OUT), lcg_next());
      add_op(1'b1, gpio_addr(b, `GPIO_REG_DIR), lcg_next());
      run_ops();
      check_pins();
    end

    // input pins need the two synchronizer stages
    rnd = lcg_next();
    gpio_in = rnd[2*`GPIO_W-1:0];
    repeat (4) @(negedge clk);
    add_readback();
    run_ops();

    add_op(1'b0, 32'h3000_0000, 32'h0);
    add_op(1'b1, 32'h3000_0000, lcg_next());
    add_op(1'b1, 32'h2000_2000, lcg_next());
    add_op(1'b0, 32'h2000_2000, 32'h0);
    add_op(1'b1, gpio_addr(0, `GPIO_REG_IN), lcg_next());
    add_op(1'b1, gpio_addr(1, 3), lcg_next());
    add_op(1'b0, gpio_addr(0, 3), 32'h0);
    run_ops();
    check_pins();
    add_readback();
    run_ops();

    $display("errors: data %0d, response %0d, pins %0d, protocol %0d, timeout %0d",
             data_errs, resp_errs, pin_errs, DUT.props.fail_cnt, timed_out);
    if (data_errs + resp_errs + pin_errs + DUT.props.fail_cnt == 0 && !timed_out)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: test/soc_properties.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module soc_properties (
  input logic                       clk,
  input logic                       reset_n,
  input logic [`APB_SLAVES_NUM-1:0] psel_i,
  input soc_pkg::apb_req_t          apb_req_i,
  input soc_pkg::ahb_rsp_t          ahb_rsp_i
);

  // failed property count
  int fail_cnt = 0;

  psel_onehot: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot0(psel_i))
  else
  begin
    fail_cnt++;
    $error("psel selects more than one apb slave");
  end

  // setup cycle with the same select comes first
  penable_after_setup: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(apb_req_i.penable) |-> $past(psel_i) == psel_i)
  else
  begin
    fail_cnt++;
    $error("penable rose without a setup cycle");
  end

  access_stable: assert property (@(posedge clk) disable iff (!reset_n)
    apb_req_i.penable |-> $stable(apb_req_i.paddr) && $stable(apb_req_i.pwrite) &&
                          $stable(apb_req_i.pwdata))
  else
  begin
    fail_cnt++;
    $error("apb request changed between setup and access");
  end

  resp_with_ready: assert property (@(posedge clk) disable iff (!reset_n)
    ahb_rsp_i.resp |-> ahb_rsp_i.ready)
  else
  begin
    fail_cnt++;
    $error("ahb error response without ready");
  end

endmodule

// File: source/riscv_soc.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module riscv_soc (
  input  logic               clk,
  input  logic               reset_n,
  input  soc_pkg::ahb_req_t  ahb_req_i,
  output soc_pkg::ahb_rsp_t  ahb_rsp_o,
  input  soc_pkg::gpio_bus_t gpio_in_i,
  output soc_pkg::gpio_bus_t gpio_out_o,
  output soc_pkg::gpio_bus_t gpio_dir_o
);

  // ahb slots: 0 iram, 1 dram, 2 apb bridge
  logic [`AHB_SLAVES_NUM-1:0] ahb_sel;
  soc_pkg::ahb_rsp_t          slv_rsp [`AHB_SLAVES_NUM];

  soc_pkg::apb_req_t          apb_req;
  soc_pkg::apb_rsp_t          apb_rsp;
  logic [`APB_SLAVES_NUM-1:0] psel;
  soc_pkg::apb_rsp_t          gpio_rsp [`APB_SLAVES_NUM];

  ahb_decoder ahb_dec (
    .clk       (clk),
    .reset_n   (reset_n),
    .ahb_req_i (ahb_req_i),
    .ahb_sel_o (ahb_sel),
    .slv_rsp_i (slv_rsp),
    .ahb_rsp_o (ahb_rsp_o)
  );

  ahb_sram #(
    .DEPTH_WORDS (`IRAM_WORDS)
  ) instr_ram (
    .clk       (clk),
    .reset_n   (reset_n),
    .sel_i     (ahb_sel[0]),
    .ahb_req_i (ahb_req_i),
    .ahb_rsp_o (slv_rsp[0])
  );

  ahb_sram #(
    .DEPTH_WORDS (`DRAM_WORDS)
  ) data_ram (
    .clk       (clk),
    .reset_n   (reset_n),
    .sel_i     (ahb_sel[1]),
    .ahb_req_i (ahb_req_i),
    .ahb_rsp_o (slv_rsp[1])
  );

  ahb_apb_bridge ahb_to_apb (
    .clk       (clk),
    .reset_n   (reset_n),
    .sel_i     (ahb_sel[2]),
    .ahb_req_i (ahb_req_i),
    .ahb_rsp_o (slv_rsp[2]),
    .apb_req_o (apb_req),
    .psel_o    (psel),
    .apb_rsp_i (apb_rsp)
  );

  for (genvar g = 0; g < `APB_SLAVES_NUM; g++)
  begin : gen_gpio
    apb_gpio gpio (
      .clk        (clk),
      .reset_n    (reset_n),
      .psel_i     (psel[g]),
      .apb_req_i  (apb_req),
      .apb_rsp_o  (gpio_rsp[g]),
      .gpio_in_i  (gpio_in_i[g]),
      .gpio_out_o (gpio_out_o[g]),
      .gpio_dir_o (gpio_dir_o[g])
    );
  end

  apb_read_mux apb_mux (
    .psel_i    (psel),
    .penable_i (apb_req.penable),
    .slv_rsp_i (gpio_rsp),
    .apb_rsp_o (apb_rsp)
  );

endmodule

// File: source/apb_read_mux.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module apb_read_mux (
  input  logic [`APB_SLAVES_NUM-1:0] psel_i,
  input  logic                       penable_i,
  input  soc_pkg::apb_rsp_t          slv_rsp_i [`APB_SLAVES_NUM],
  output soc_pkg::apb_rsp_t          apb_rsp_o
);

  // psel is one-hot, so at most one slave wins
  always_comb
  begin
    apb_rsp_o.prdata = '0;
    apb_rsp_o.pready = 1'b1;
    // access with no select is an unmapped apb address
    apb_rsp_o.pslverr = penable_i & ~|psel_i;
    if (penable_i)
    begin
      for (int i = 0; i < `APB_SLAVES_NUM; i++)
      begin
        if (psel_i[i])
          apb_rsp_o = slv_rsp_i[i];
      end
    end
  end

endmodule

// File: source/apb_gpio.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module apb_gpio (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                psel_i,
  input  soc_pkg::apb_req_t   apb_req_i,
  output soc_pkg::apb_rsp_t   apb_rsp_o,
  input  soc_pkg::gpio_word_t gpio_in_i,
  output soc_pkg::gpio_word_t gpio_out_o,
  output soc_pkg::gpio_word_t gpio_dir_o
);

  // word offset inside the 4 KB block
  localparam logic [9:0] OFF_OUT = 10'(`GPIO_REG_OUT);
  localparam logic [9:0] OFF_DIR = 10'(`GPIO_REG_DIR);
  localparam logic [9:0] OFF_IN = 10'(`GPIO_REG_IN);

  logic [9:0]          offset;
  logic                access;
  logic                bad_reg;
  logic                wr_en;
  soc_pkg::gpio_word_t rd_word;
  soc_pkg::gpio_word_t in_meta_q;
  soc_pkg::gpio_word_t in_sync_q;

  assign offset = apb_req_i.paddr[11:2];
  assign access = psel_i & apb_req_i.penable;

  always_comb
  begin
    rd_word = '0;
    bad_reg = 1'b0;
    case (offset)
      OFF_OUT: rd_word = gpio_out_o;
      OFF_DIR: rd_word = gpio_dir_o;
      OFF_IN:
      begin
        // read only
        rd_word = in_sync_q;
        bad_reg = apb_req_i.pwrite;
      end
      default: bad_reg = 1'b1;
    endcase
  end

  assign wr_en = access & apb_req_i.pwrite & ~bad_reg;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      gpio_out_o <= '0;
      gpio_dir_o <= '0;
      in_meta_q <= '0;
      in_sync_q <= '0;
    end
    else
    begin
      if (wr_en && offset == OFF_OUT)
        gpio_out_o <= apb_req_i.pwdata[`GPIO_W-1:0];
      if (wr_en && offset == OFF_DIR)
        gpio_dir_o <= apb_req_i.pwdata[`GPIO_W-1:0];
      // two-stage synchronizer on the pins
      in_meta_q <= gpio_in_i;
      in_sync_q <= in_meta_q;
    end
  end

  assign apb_rsp_o.prdata = {{(`SOC_DATA_W-`GPIO_W){1'b0}}, rd_word};
  assign apb_rsp_o.pready = 1'b1;
  assign apb_rsp_o.pslverr = access & bad_reg;

endmodule

// File: source/ahb_apb_bridge.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module ahb_apb_bridge (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       sel_i,
  input  soc_pkg::ahb_req_t          ahb_req_i,
  output soc_pkg::ahb_rsp_t          ahb_rsp_o,
  output soc_pkg::apb_req_t          apb_req_o,
  output logic [`APB_SLAVES_NUM-1:0] psel_o,
  input  soc_pkg::apb_rsp_t          apb_rsp_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS,
    ST_RESP
  } state_t;

  state_t                     state_q;
  state_t                     state_d;
  logic [`APB_SLAVES_NUM-1:0] psel_hit;
  logic [`APB_SLAVES_NUM-1:0] psel_q;
  logic [`SOC_ADDR_W-1:0]     addr_q;
  logic                       write_q;
  logic [`SOC_DATA_W-1:0]     wdata_q;
  logic [`SOC_DATA_W-1:0]     rdata_q;
  logic                       err_q;

  // gpio windows, no hit leaves psel empty
  always_comb
  begin
    psel_hit = '0;
    for (int i = 0; i < `APB_SLAVES_NUM; i++)
    begin
      if ((ahb_req_i.addr & `GPIO_MASK) == `SOC_ADDR_W'(`GPIO_BASE + i * `GPIO_STRIDE))
        psel_hit[i] = 1'b1;
    end
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:   if (sel_i) state_d = ST_SETUP;
      ST_SETUP:  state_d = ST_ACCESS;
      ST_ACCESS: if (apb_rsp_i.pready) state_d = ST_RESP;
      // ready is high here, so a new transfer may already start
      ST_RESP:   state_d = sel_i ? ST_SETUP : ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q <= ST_IDLE;
      psel_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (sel_i)
        psel_q <= psel_hit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (sel_i)
    begin
      addr_q <= ahb_req_i.addr;
      write_q <= ahb_req_i.write;
    end
    if (state_q == ST_SETUP)
      wdata_q <= ahb_req_i.wdata;
    if (state_q == ST_ACCESS && apb_rsp_i.pready)
    begin
      rdata_q <= apb_rsp_i.prdata;
      err_q <= apb_rsp_i.pslverr;
    end
  end

  assign apb_req_o.penable = (state_q == ST_ACCESS);
  assign apb_req_o.pwrite = write_q;
  assign apb_req_o.paddr = addr_q;
  // hwdata first shows up in setup, access uses the captured copy
  assign apb_req_o.pwdata = (state_q == ST_SETUP) ? ahb_req_i.wdata : wdata_q;

  assign psel_o = (state_q == ST_SETUP || state_q == ST_ACCESS) ? psel_q : '0;

  assign ahb_rsp_o.ready = (state_q == ST_IDLE) || (state_q == ST_RESP);
  assign ahb_rsp_o.resp = (state_q == ST_RESP) & err_q;
  assign ahb_rsp_o.rdata = rdata_q;

endmodule

// File: source/ahb_sram.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module ahb_sram #(
  parameter int DEPTH_WORDS = 256
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              sel_i,
  input  soc_pkg::ahb_req_t ahb_req_i,
  output soc_pkg::ahb_rsp_t ahb_rsp_o
);

  localparam int IDX_W = $clog2(DEPTH_WORDS);

  logic [`SOC_DATA_W-1:0] mem [DEPTH_WORDS];
  logic [IDX_W-1:0]       idx_q;
  logic                   wr_pend_q;

  // write pending for the coming data phase
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      wr_pend_q <= 1'b0;
    else
      wr_pend_q <= sel_i & ahb_req_i.write;
  end

  // index of the transfer now in its data phase
  always_ff @(posedge clk)
  begin
    if (sel_i)
      idx_q <= ahb_req_i.addr[IDX_W+1:2];
  end

  // commit at the end of the data phase, old index still valid here
  always_ff @(posedge clk)
  begin
    if (wr_pend_q)
      mem[idx_q] <= ahb_req_i.wdata;
  end

  // no wait states, word read straight out of the array
  assign ahb_rsp_o.rdata = mem[idx_q];
  assign ahb_rsp_o.ready = 1'b1;
  assign ahb_rsp_o.resp = 1'b0;

endmodule

// File: source/ahb_decoder.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module ahb_decoder (
  input  logic                       clk,
  input  logic                       reset_n,
  input  soc_pkg::ahb_req_t          ahb_req_i,
  output logic [`AHB_SLAVES_NUM-1:0] ahb_sel_o,
  input  soc_pkg::ahb_rsp_t          slv_rsp_i [`AHB_SLAVES_NUM],
  output soc_pkg::ahb_rsp_t          ahb_rsp_o
);

  localparam int IDX_W = $clog2(`AHB_SLAVES_NUM);

  // slot order is iram, dram, apb bridge
  localparam logic [`SOC_ADDR_W-1:0] SLV_BASE [`AHB_SLAVES_NUM] =
    '{`IRAM_BASE, `DRAM_BASE, `APB_BASE};
  localparam logic [`SOC_ADDR_W-1:0] SLV_MASK [`AHB_SLAVES_NUM] =
    '{`IRAM_MASK, `DRAM_MASK, `APB_MASK};

  logic [`AHB_SLAVES_NUM-1:0] hit;
  logic [IDX_W-1:0]           hit_idx;
  logic                       dphase_q;
  logic                       derr_q;
  logic [IDX_W-1:0]           didx_q;

  always_comb
  begin
    hit = '0;
    hit_idx = '0;
    for (int i = 0; i < `AHB_SLAVES_NUM; i++)
    begin
      if ((ahb_req_i.addr & SLV_MASK[i]) == SLV_BASE[i])
      begin
        hit[i] = 1'b1;
        hit_idx = IDX_W'(i);
      end
    end
  end

  // select only in an accepted address phase
  assign ahb_sel_o = hit & {`AHB_SLAVES_NUM{ahb_req_i.trans & ahb_rsp_o.ready}};

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      dphase_q <= 1'b0;
      derr_q <= 1'b0;
      didx_q <= '0;
    end
    else if (ahb_rsp_o.ready)
    begin
      dphase_q <= ahb_req_i.trans;
      derr_q <= ahb_req_i.trans & ~|hit;
      didx_q <= hit_idx;
    end
  end

  // default slave answers idle cycles and unmapped addresses
  always_comb
  begin
    if (dphase_q && !derr_q)
      ahb_rsp_o = slv_rsp_i[didx_q];
    else
    begin
      ahb_rsp_o.rdata = '0;
      ahb_rsp_o.ready = 1'b1;
      ahb_rsp_o.resp = derr_q;
    end
  end

endmodule

// File: source/soc_pkg.sv
`include "soc_defines.svh"

package soc_pkg;

  // ahb-lite request from the single master
  typedef struct packed {
    logic                   trans;
    logic                   write;
    logic [`SOC_ADDR_W-1:0] addr;
    // data phase, held by the master until ready
    logic [`SOC_DATA_W-1:0] wdata;
  } ahb_req_t;

  typedef struct packed {
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   ready;
    logic                   resp;
  } ahb_rsp_t;

  // shared by every apb slave, psel travels apart
  typedef struct packed {
    logic                   penable;
    logic                   pwrite;
    logic [`SOC_ADDR_W-1:0] paddr;
    logic [`SOC_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`SOC_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } apb_rsp_t;

  typedef logic [`GPIO_W-1:0] gpio_word_t;

  // one slice per gpio block
  typedef gpio_word_t [`APB_SLAVES_NUM-1:0] gpio_bus_t;

endpackage

// File: source/soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// slave counts, one gpio block per apb slot
`define AHB_SLAVES_NUM 3
`define APB_SLAVES_NUM 2
`define GPIO_W 8

// sram depths in words
`define IRAM_WORDS 256
`define DRAM_WORDS 128

// ahb memory map
`define IRAM_BASE 32'h0000_0000
`define IRAM_MASK 32'hFFFF_FC00
`define DRAM_BASE 32'h1000_0000
`define DRAM_MASK 32'hFFFF_FE00
`define APB_BASE 32'h2000_0000
`define APB_MASK 32'hFFFF_0000

// apb map, one 4 KB window per gpio block
`define GPIO_BASE 32'h2000_0000
`define GPIO_STRIDE 32'h0000_1000
`define GPIO_MASK 32'hFFFF_F000

// word offsets inside a gpio block
`define GPIO_REG_OUT 0
`define GPIO_REG_DIR 1
`define GPIO_REG_IN 2

`endif
